/* Makefile */
# Verilator build for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?=
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv testbench/*.sv include/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status is nonzero when the testbench reaches $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+include
source/cache_pkg.sv
source/fetch_pkg.sv
source/icache_request_buffer.sv
source/icache_lru.sv
source/icache_way_array.sv
source/icache_controller.sv
source/icache.sv
testbench/icache_chk.sv
testbench/icache_tb.sv

/* include/icache_macros.svh */
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry

// number of sets as a power of two
`define ICACHE_INDEX_WIDTH 4

// words per line as a power of two
`define ICACHE_OFFSET_WIDTH 2

// associativity
`define ICACHE_WAYS 2

`endif

/* source/cache_pkg.sv */
`include "icache_macros.svh"

package cache_pkg;

    // tag takes everything above index, word offset and byte offset
    localparam int TAG_WIDTH = 32 - `ICACHE_INDEX_WIDTH - `ICACHE_OFFSET_WIDTH - 2;
    localparam int LINE_WORDS = 1 << `ICACHE_OFFSET_WIDTH;
    localparam int SETS = 1 << `ICACHE_INDEX_WIDTH;

    typedef logic [`ICACHE_INDEX_WIDTH-1:0] index_t;

    typedef logic [TAG_WIDTH-1:0] tag_t;

    // one entry of the tag array
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // one cache line, word 0 at the lowest address
    typedef logic [LINE_WORDS-1:0][31:0] line_t;

endpackage

/* source/fetch_pkg.sv */
`include "icache_macros.svh"

package fetch_pkg;

    // field positions within a fetch address
    localparam int OFFSET_LSB = 2;
    localparam int INDEX_LSB = OFFSET_LSB + `ICACHE_OFFSET_WIDTH;
    localparam int TAG_LSB = INDEX_LSB + `ICACHE_INDEX_WIDTH;

    typedef logic [`ICACHE_OFFSET_WIDTH-1:0] offset_t;

    // [0] is the word at the fetch address, [1] the next one
    typedef logic [1:0][31:0] instr_pair_t;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h00000013;

endpackage

/* source/icache.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     fetch_valid,
    input  logic [31:0]              fetch_addr,
    output logic                     fetch_ready,
    output logic                     rsp_valid,
    output fetch_pkg::instr_pair_t   rsp_data,
    output logic                     rsp_second_valid,
    output logic                     mem_req,
    output logic [31:0]              mem_addr,
    input  logic                     mem_ack,
    input  cache_pkg::line_t         mem_line
);

    cache_pkg::index_t     rbuf_index;
    cache_pkg::tag_t       rbuf_tag;
    fetch_pkg::offset_t    rbuf_offset;
    cache_pkg::index_t     read_index;

    cache_pkg::tag_entry_t tag_entries [`ICACHE_WAYS];
    cache_pkg::tag_entry_t new_tag_entry;
    cache_pkg::line_t      line_entries [`ICACHE_WAYS];
    cache_pkg::line_t      refill_line;
    cache_pkg::line_t      selected_line;

    logic buffer_load;
    logic victim_way;
    logic lru_update;
    logic touched_way;
    logic refill_capture;
    logic use_refill;
    logic hit_way;
    logic [`ICACHE_WAYS-1:0] tag_write_way;
    logic [`ICACHE_WAYS-1:0] data_write_way;

    // arrays read with the live address in the accept cycle
    assign read_index = fetch_addr[fetch_pkg::INDEX_LSB +: `ICACHE_INDEX_WIDTH];

    icache_request_buffer u_request_buffer (
        .clk        (clk),
        .reset      (reset),
        .load       (buffer_load),
        .fetch_addr (fetch_addr),
        .index      (rbuf_index),
        .tag        (rbuf_tag),
        .offset     (rbuf_offset)
    );

    icache_lru u_lru (
        .clk         (clk),
        .reset       (reset),
        .index       (rbuf_index),
        .update      (lru_update),
        .touched_way (touched_way),
        .victim_way  (victim_way)
    );

    assign new_tag_entry.valid = 1'b1;
    assign new_tag_entry.tag   = rbuf_tag;

    icache_way_array #(
        .entry_t (cache_pkg::tag_entry_t),
        .WAYS    (`ICACHE_WAYS)
    ) u_tag_array (
        .clk          (clk),
        .reset        (reset),
        .read_index   (read_index),
        .read_entries (tag_entries),
        .write_way    (tag_write_way),
        .write_index  (rbuf_index),
        .write_entry  (new_tag_entry)
    );

    icache_way_array #(
        .entry_t (cache_pkg::line_t),
        .WAYS    (`ICACHE_WAYS)
    ) u_data_array (
        .clk          (clk),
        .reset        (reset),
        .read_index   (read_index),
        .read_entries (line_entries),
        .write_way    (data_write_way),
        .write_index  (rbuf_index),
        .write_entry  (mem_line)
    );

    icache_controller u_controller (
        .clk            (clk),
        .reset          (reset),
        .fetch_valid    (fetch_valid),
        .fetch_ready    (fetch_ready),
        .buffer_load    (buffer_load),
        .tag_entries    (tag_entries),
        .request_tag    (rbuf_tag),
        .request_index  (rbuf_index),
        .victim_way     (victim_way),
        .lru_update     (lru_update),
        .touched_way    (touched_way),
        .tag_write_way  (tag_write_way),
        .data_write_way (data_write_way),
        .mem_req        (mem_req),
        .mem_ack        (mem_ack),
        .refill_capture (refill_capture),
        .use_refill     (use_refill),
        .hit_way        (hit_way),
        .rsp_valid      (rsp_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // refill path
    ////////////////////////////////////////////////////////////////////////////

    // line-aligned, low bits zero
    assign mem_addr = {rbuf_tag, rbuf_index, {(`ICACHE_OFFSET_WIDTH + 2){1'b0}}};

    // copy of the returned line for the response cycle
    always_ff @(posedge clk) begin
        if (refill_capture) begin
            refill_line <= mem_line;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction pair select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        selected_line = use_refill ? refill_line : line_entries[hit_way];
        rsp_data[0] = selected_line[rbuf_offset];
        if (!rbuf_offset[0]) begin
            // even offset, next word is in the same aligned pair
            rsp_data[1] = selected_line[fetch_pkg::offset_t'(rbuf_offset + 1'b1)];
            rsp_second_valid = 1'b1;
        end else begin
            rsp_data[1] = fetch_pkg::NOP_WORD;
            rsp_second_valid = 1'b0;
        end
    end

endmodule

/* source/icache_controller.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_controller (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fetch_valid,
    output logic                      fetch_ready,
    output logic                      buffer_load,
    input  cache_pkg::tag_entry_t     tag_entries [`ICACHE_WAYS],
    input  cache_pkg::tag_t           request_tag,
    input  cache_pkg::index_t         request_index,
    input  logic                      victim_way,
    output logic                      lru_update,
    output logic                      touched_way,
    output logic [`ICACHE_WAYS-1:0]   tag_write_way,
    output logic [`ICACHE_WAYS-1:0]   data_write_way,
    output logic                      mem_req,
    input  logic                      mem_ack,
    output logic                      refill_capture,
    output logic                      use_refill,
    output logic                      hit_way,
    output logic                      rsp_valid
);

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_REFILL,
        S_RESPOND,
        S_RELEASE
    } state_t;

    state_t state;
    state_t state_next;

    logic lookup_valid;
    logic hit;
    logic lookup_hit;
    logic lookup_miss;
    logic refill_write;
    cache_pkg::index_t miss_index;
    logic [`ICACHE_WAYS-1:0] victim_onehot;

    ////////////////////////////////////////////////////////////////////////////
    // tag compare, the arrays hold the set read at accept
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        hit = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (tag_entries[w].valid && tag_entries[w].tag == request_tag) begin
                hit = 1'b1;
                hit_way = w[0];
            end
        end
    end

    assign lookup_hit  = lookup_valid && hit;
    assign lookup_miss = lookup_valid && !hit;

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            S_LOOKUP: begin
                if (lookup_miss) begin
                    state_next = S_REFILL;
                end
            end
            S_REFILL: begin
                if (mem_ack) begin
                    state_next = S_RESPOND;
                end
            end
            // memory may still hold ack after the response
            S_RESPOND: state_next = mem_ack ? S_RELEASE : S_LOOKUP;
            S_RELEASE: state_next = mem_ack ? S_RELEASE : S_LOOKUP;
            default:   state_next = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_LOOKUP;
            lookup_valid <= 1'b0;
        end else begin
            state <= state_next;
            lookup_valid <= buffer_load;
        end
    end

    // set under refill, latched when the miss is seen
    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            miss_index <= request_index;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////////////////////

    // a miss in the lookup cycle blocks the next accept at once
    assign fetch_ready = (state == S_LOOKUP) && !lookup_miss;
    assign buffer_load = fetch_valid && fetch_ready;

    assign mem_req = (state == S_REFILL);
    assign refill_capture = (state == S_REFILL) && mem_ack;

    // write only into the set that missed
    assign refill_write = refill_capture && (request_index == miss_index);

    always_comb begin
        victim_onehot = '0;
        victim_onehot[victim_way] = 1'b1;
    end

    assign tag_write_way  = refill_write ? victim_onehot : '0;
    assign data_write_way = refill_write ? victim_onehot : '0;

    assign lru_update  = lookup_hit || refill_write;
    assign touched_way = refill_write ? victim_way : hit_way;

    assign use_refill = (state == S_RESPOND);
    assign rsp_valid  = lookup_hit || (state == S_RESPOND);

endmodule

/* source/icache_lru.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_lru (
    input  logic               clk,
    input  logic               reset,
    input  cache_pkg::index_t  index,
    input  logic               update,
    input  logic               touched_way,
    output logic               victim_way
);

    localparam int SETS = 1 << `ICACHE_INDEX_WIDTH;

    // one bit per set naming the way used least recently
    logic [SETS-1:0] lru_bits;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (update) begin
            // the other way becomes the next victim
            lru_bits[index] <= ~touched_way;
        end
    end

    assign victim_way = lru_bits[index];

endmodule

/* source/icache_request_buffer.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_request_buffer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  logic [31:0]          fetch_addr,
    output cache_pkg::index_t    index,
    output cache_pkg::tag_t      tag,
    output fetch_pkg::offset_t   offset
);

    logic [31:0] addr_q;

    // holds the address from accept until the response leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_q <= '0;
        end else if (load) begin
            addr_q <= fetch_addr;
        end
    end

    // field split for lookup and refill
    assign offset = addr_q[fetch_pkg::OFFSET_LSB +: `ICACHE_OFFSET_WIDTH];
    assign index  = addr_q[fetch_pkg::INDEX_LSB +: `ICACHE_INDEX_WIDTH];
    assign tag    = addr_q[31:fetch_pkg::TAG_LSB];

endmodule

/* source/icache_way_array.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_way_array #(
    parameter type entry_t = logic [31:0],
    parameter int  WAYS    = `ICACHE_WAYS
) (
    input  logic               clk,
    input  logic               reset,
    input  cache_pkg::index_t  read_index,
    output entry_t             read_entries [WAYS],
    input  logic [WAYS-1:0]    write_way,
    input  cache_pkg::index_t  write_index,
    input  entry_t             write_entry
);

    localparam int SETS = 1 << `ICACHE_INDEX_WIDTH;

    entry_t storage [WAYS][SETS];

    ////////////////////////////////////////////////////////////////////////////
    // storage, cleared so every tag starts invalid
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    storage[w][s] <= '0;
                end
                read_entries[w] <= '0;
            end
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                // all ways read together, one cycle later
                read_entries[w] <= storage[w][read_index];
                if (write_way[w]) begin
                    storage[w][write_index] <= write_entry;
                end
            end
        end
    end

endmodule

/* testbench/icache_chk.sv */
`timescale 1ns/1ps

module icache_chk (
    input logic        clk,
    input logic        reset,
    input logic        fetch_ready,
    input logic        rsp_valid,
    input logic        mem_req,
    input logic [31:0] mem_addr,
    input logic        mem_ack
);

    // request holds until memory answers
    req_held: assert property (@(posedge clk) disable iff (reset)
        (mem_req && !mem_ack) |=> mem_req)
        else $error("mem_req dropped before mem_ack");

    // address stays put while the request waits
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_req && !mem_ack) |=> (mem_addr == $past(mem_addr)))
        else $error("mem_addr changed while mem_req was high");

    // four-phase return to zero before the next request
    no_req_during_ack: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !mem_ack)
        else $error("new mem_req while mem_ack still high");

    // refill response is a single cycle
    single_refill_rsp: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && !fetch_ready) |=> !rsp_valid)
        else $error("rsp_valid lasted two cycles during a refill");

endmodule

/* include/icache_tb_macros.svh */
`ifndef ICACHE_TB_MACROS_SVH
`define ICACHE_TB_MACROS_SVH

// testbench run length
`define TB_REQUESTS 600

// worst case cycles for one request, refill included
`define TB_CYCLES_PER_REQUEST 12

// clock period in ns
`define TB_CLOCK_PERIOD 4

`endif

/* testbench/icache_tb.sv */
`timescale 1ns/1ps
`include "icache_macros.svh"
`include "icache_tb_macros.svh"

module icache_tb;

    localparam int SETS = 1 << `ICACHE_INDEX_WIDTH;

    logic                    clk;
    logic                    reset;
    logic                    fetch_valid;
    logic [31:0]             fetch_addr;
    logic                    fetch_ready;
    logic                    rsp_valid;
    fetch_pkg::instr_pair_t  rsp_data;
    logic                    rsp_second_valid;
    logic                    mem_req;
    logic [31:0]             mem_addr;
    logic                    mem_ack;
    cache_pkg::line_t        mem_line;

    // reference model state
    logic                    model_valid [`ICACHE_WAYS][SETS];
    cache_pkg::tag_t         model_tag [`ICACHE_WAYS][SETS];
    logic                    model_lru [SETS];

    // expected responses in order, plus expected refill addresses
    fetch_pkg::instr_pair_t  exp_data [$];
    logic                    exp_second [$];
    logic                    exp_hit [$];
    int                      exp_cycle [$];
    logic [31:0]             exp_refill [$];

    logic [31:0] rng;
    logic [31:0] resp_rng;
    int          cycle;
    int          accepted;
    logic        prev_mem_req;
    int          ack_delay;
    int          ack_wait;

    icache DUT (
        .clk              (clk),
        .reset            (reset),
        .fetch_valid      (fetch_valid),
        .fetch_addr       (fetch_addr),
        .fetch_ready      (fetch_ready),
        .rsp_valid        (rsp_valid),
        .rsp_data         (rsp_data),
        .rsp_second_valid (rsp_second_valid),
        .mem_req          (mem_req),
        .mem_addr         (mem_addr),
        .mem_ack          (mem_ack),
        .mem_line         (mem_line)
    );

    bind icache icache_chk u_chk (
        .clk         (clk),
        .reset       (reset),
        .fetch_ready (fetch_ready),
        .rsp_valid   (rsp_valid),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack)
    );

    always #(`TB_CLOCK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // memory content rule
    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
        return {byte_addr[31:2], 2'b00} ^ 32'hA5A50000;
    endfunction

    function automatic logic [31:0] make_addr(input logic [31:0] r);
        cache_pkg::tag_t tag;
        case (r[21:20] % 3)
            0:       tag = cache_pkg::tag_t'(26'h0000001);
            1:       tag = cache_pkg::tag_t'(26'h0000002);
            default: tag = cache_pkg::tag_t'(26'h00003a5);
        endcase
        return {tag, r[11:8], r[5:4], 2'b00};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model, two ways with one LRU bit per set
    ////////////////////////////////////////////////////////////////////////////

    task automatic predict_access(input logic [31:0] addr, input int at_cycle);
        cache_pkg::tag_t        tag;
        int                     set;
        int                     way;
        logic                   hit;
        fetch_pkg::instr_pair_t pair;
        tag = addr[31:fetch_pkg::TAG_LSB];
        set = int'(addr[fetch_pkg::INDEX_LSB +: `ICACHE_INDEX_WIDTH]);
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (model_valid[w][set] && model_tag[w][set] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = int'(model_lru[set]);
            model_valid[way][set] = 1'b1;
            model_tag[way][set] = tag;
            exp_refill.push_back({addr[31:4], 4'h0});
        end
        model_lru[set] = (way == 0);
        pair[0] = mem_word(addr);
        if (!addr[2]) begin
            pair[1] = mem_word(addr + 32'd4);
        end else begin
            pair[1] = fetch_pkg::NOP_WORD;
        end
        exp_data.push_back(pair);
        exp_second.push_back(!addr[2]);
        exp_hit.push_back(hit);
        exp_cycle.push_back(at_cycle);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and response checks
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset) begin
            // refill requests against the model
            if (mem_req && !prev_mem_req) begin
                assert (exp_refill.size() > 0)
                else report_failure("memory request without a predicted miss");
                assert (mem_addr == exp_refill[0])
                else report_mismatch($sformatf("mem_addr %h, expected %h",
                                               mem_addr, exp_refill[0]));
                void'(exp_refill.pop_front());
            end
            prev_mem_req <= mem_req;

            if (rsp_valid) begin
                assert (exp_data.size() > 0)
                else report_failure("response with no request outstanding");
                assert (rsp_data == exp_data[0])
                else report_mismatch($sformatf("rsp_data %h, expected %h",
                                               rsp_data, exp_data[0]));
                assert (rsp_second_valid == exp_second[0])
                else report_mismatch($sformatf("rsp_second_valid %b, expected %b",
                                               rsp_second_valid, exp_second[0]));
                // hits answer in the cycle right after accept
                if (exp_hit[0]) begin
                    assert (cycle == exp_cycle[0] + 1)
                    else report_mismatch($sformatf("hit answered %0d cycles after accept",
                                                   cycle - exp_cycle[0]));
                end
                void'(exp_data.pop_front());
                void'(exp_second.pop_front());
                void'(exp_hit.pop_front());
                void'(exp_cycle.pop_front());
            end

            if (fetch_valid && fetch_ready) begin
                predict_access(fetch_addr, cycle);
                accepted++;
            end

            // new request once the old one is taken or none is pending
            if (!fetch_valid || fetch_ready) begin
                rng = lcg_next(rng);
                if (accepted < `TB_REQUESTS) begin
                    fetch_valid <= (rng[30:28] != 3'd0);
                    fetch_addr <= make_addr(rng);
                end else begin
                    fetch_valid <= 1'b0;
                end
            end
            cycle++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (reset) begin
            ack_wait <= 0;
        end else if (mem_req && !mem_ack) begin
            if (ack_wait == 0) begin
                resp_rng = lcg_next(resp_rng);
                ack_delay = int'(resp_rng[18:16]) % 6;
            end
            if (ack_wait >= ack_delay) begin
                mem_ack <= 1'b1;
                for (int i = 0; i < cache_pkg::LINE_WORDS; i++) begin
                    mem_line[i] <= mem_word(mem_addr + 32'(4 * i));
                end
                ack_wait <= 0;
            end else begin
                ack_wait <= ack_wait + 1;
            end
        end else if (mem_ack && !mem_req) begin
            // ack release takes a random delay of its own
            if (ack_wait == 0) begin
                resp_rng = lcg_next(resp_rng);
                ack_delay = int'(resp_rng[18:16]) % 4;
            end
            if (ack_wait >= ack_delay) begin
                mem_ack <= 1'b0;
                ack_wait <= 0;
            end else begin
                ack_wait <= ack_wait + 1;
            end
        end
    end

    // watchdog
    initial begin
        #(`TB_REQUESTS * `TB_CYCLES_PER_REQUEST * `TB_CLOCK_PERIOD);
        $display("timeout, the run did not finish in time");
        $display("test failed");
        $fatal(1);
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_addr = '0;
        mem_ack = 1'b0;
        mem_line = '0;
        rng = 32'h849;
        resp_rng = lcg_next(32'h849 ^ 32'h5a5a5a5a);
        cycle = 0;
        accepted = 0;
        prev_mem_req = 1'b0;
        ack_delay = 0;
        ack_wait = 0;
        for (int s = 0; s < SETS; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s] = '0;
            end
        end

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!mem_req && !rsp_valid && fetch_ready)
        else report_mismatch("handshake outputs wrong after reset");

        while (accepted < `TB_REQUESTS || exp_data.size() > 0 || mem_req || mem_ack) begin
            @(negedge clk);
        end
        @(negedge clk);

        if (exp_refill.size() == 0 && exp_data.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("predicted refills never requested by the cache");
            $display("test failed");
            $fatal(1);
        end
    end

endmodule
